//--- verilog/led_pkg.sv
package led_pkg;

    //--------------------------------------------------------------------------
    // host settings
    //--------------------------------------------------------------------------
    typedef logic [3:0] setting_t;

    localparam setting_t BLINK_STEADY_ON  = 4'd0;
    localparam setting_t BLINK_STEADY_OFF = 4'd8;
    localparam setting_t MAX_RATE_CODE    = 4'd7;    // highest timed blink/ramp code

    // reset defaults: red, mid brightness, no ramp, 1 s blink
    localparam setting_t DEF_COLOUR = 4'd0;
    localparam setting_t DEF_BRIGHT = 4'd7;
    localparam setting_t DEF_RAMP   = 4'd0;
    localparam setting_t DEF_BLINK  = 4'd5;

    //--------------------------------------------------------------------------
    // datapath widths
    //--------------------------------------------------------------------------
    localparam int INTENS_W = 5;                  // brightness + 1, up to 16
    localparam int ACCUM_W  = 22;                 // peak and accumulator
    localparam int STEP_W   = 24;
    localparam int DUTY_W   = 9;                  // 256 is fully on
    localparam int DUTY_LSB = 13;
    localparam int SHIFT_W  = 5;

    localparam int PWM_PERIOD = 256;
    localparam int PWM_CNT_W  = $clog2(PWM_PERIOD);

    //--------------------------------------------------------------------------
    // blink timing, in clk32K cycles
    //--------------------------------------------------------------------------
    localparam int STEADY_W        = 22;
    localparam int RAMP_W          = 20;
    localparam int ON_MAX_CNT      = 32768;       // one second steady on
    localparam int OFF_BASE_CNT    = 2048;        // blink code 1
    localparam int RAMP_BASE_CNT   = 1024;        // ramp code 1
    localparam int RAMP_BASE_SHIFT = 10;

    typedef enum logic [1:0] {
        LVL_OFF = 2'b00,
        LVL_LO  = 2'b01,
        LVL_HI  = 2'b10
    } level_t;

    typedef enum logic [1:0] {
        LED_OFF   = 2'b00,
        RAMP_UP   = 2'b01,
        LED_ON    = 2'b10,
        RAMP_DOWN = 2'b11
    } blink_state_t;

    typedef enum logic [3:0] {
        RED = 4'd0, ORANGE, YELLOW, CHARTREUSE, GREEN, SPRING, CYAN, AZURE,
        BLUE, VIOLET, MAGENTA, ROSE,
        WHITE = 4'd15                              // 12 to 14 stay dark
    } colour_t;

endpackage

//--- verilog/led_param_capture.sv
`timescale 1ns/10ps

module led_param_capture (
    input  logic              clk32K,
    input  logic              rst,
    input  logic              params_ok,
    input  led_pkg::setting_t rgb_color,
    input  led_pkg::setting_t brightness,
    input  led_pkg::setting_t breathe_ramp,
    input  led_pkg::setting_t blink_rate,
    output logic              update,
    output led_pkg::setting_t colour_s,
    output led_pkg::setting_t bright_s,
    output led_pkg::setting_t ramp_s,
    output led_pkg::setting_t blink_s
);
    import led_pkg::*;

    logic [2:0] ok_sync;    // two sync flops plus edge history

    always_ff @(posedge clk32K or posedge rst) begin
        if (rst) begin
            ok_sync <= '0;
            update  <= 1'b0;
        end else begin
            ok_sync <= {ok_sync[1:0], params_ok};
            update  <= ok_sync[1] & ~ok_sync[2];    // rising edge
        end
    end

    // settings are stable while params_ok is high
    always_ff @(posedge clk32K or posedge rst) begin
        if (rst) begin
            colour_s <= DEF_COLOUR;
            bright_s <= DEF_BRIGHT;
            ramp_s   <= DEF_RAMP;
            blink_s  <= DEF_BLINK;
        end else if (update) begin
            colour_s <= rgb_color;
            bright_s <= brightness;
            ramp_s   <= breathe_ramp;
            blink_s  <= blink_rate;
        end
    end

endmodule

//--- verilog/led_colour_peak.sv
`timescale 1ns/10ps

module led_colour_peak (
    input  logic                         clk32K,
    input  logic                         rst,
    input  led_pkg::setting_t            colour_s,
    input  led_pkg::setting_t            bright_s,
    output logic [led_pkg::ACCUM_W-1:0]  red_peak,
    output logic [led_pkg::ACCUM_W-1:0]  grn_peak,
    output logic [led_pkg::ACCUM_W-1:0]  blu_peak
);
    import led_pkg::*;

    level_t              red_lvl;
    level_t              grn_lvl;
    level_t              blu_lvl;
    logic [INTENS_W-1:0] intensity;

    // hi puts the intensity at the top of the peak, lo one bit lower
    function automatic logic [ACCUM_W-1:0] level_peak(level_t lvl,
                                                      logic [INTENS_W-1:0] inten);
        logic [ACCUM_W-1:0] full;
        full = {inten, {(ACCUM_W-INTENS_W){1'b0}}};
        case (lvl)
            LVL_HI:  return full;
            LVL_LO:  return full >> 1;
            default: return '0;
        endcase
    endfunction

    assign intensity = INTENS_W'(bright_s) + 1'b1;    // shared by all channels

    always_comb begin
        red_lvl = LVL_OFF;
        grn_lvl = LVL_OFF;
        blu_lvl = LVL_OFF;
        case (colour_t'(colour_s))
            RED:        red_lvl = LVL_HI;
            ORANGE:     begin red_lvl = LVL_HI; grn_lvl = LVL_LO; end
            YELLOW:     begin red_lvl = LVL_HI; grn_lvl = LVL_HI; end
            CHARTREUSE: begin red_lvl = LVL_LO; grn_lvl = LVL_HI; end
            GREEN:      grn_lvl = LVL_HI;
            SPRING:     begin grn_lvl = LVL_HI; blu_lvl = LVL_LO; end
            CYAN:       begin grn_lvl = LVL_HI; blu_lvl = LVL_HI; end
            AZURE:      begin grn_lvl = LVL_LO; blu_lvl = LVL_HI; end
            BLUE:       blu_lvl = LVL_HI;
            VIOLET:     begin red_lvl = LVL_LO; blu_lvl = LVL_HI; end
            MAGENTA:    begin red_lvl = LVL_HI; blu_lvl = LVL_HI; end
            ROSE:       begin red_lvl = LVL_HI; blu_lvl = LVL_LO; end
            WHITE: begin
                red_lvl = LVL_HI;
                grn_lvl = LVL_HI;
                blu_lvl = LVL_HI;
            end
            default:    ;    // dark codes
        endcase
    end

    always_ff @(posedge clk32K or posedge rst) begin
        if (rst) begin
            red_peak <= '0;
            grn_peak <= '0;
            blu_peak <= '0;
        end else begin
            red_peak <= level_peak(red_lvl, intensity);
            grn_peak <= level_peak(grn_lvl, intensity);
            blu_peak <= level_peak(blu_lvl, intensity);
        end
    end

endmodule

//--- verilog/led_rate_decode.sv
`timescale 1ns/10ps

module led_rate_decode (
    input  logic                          clk32K,
    input  logic                          rst,
    input  led_pkg::setting_t             blink_s,
    input  led_pkg::setting_t             ramp_s,
    output logic [led_pkg::STEADY_W-1:0]  off_max_cnt,
    output logic [led_pkg::RAMP_W-1:0]    ramp_max_cnt,
    output logic [led_pkg::SHIFT_W-1:0]   step_shift
);
    import led_pkg::*;

    //--------------------------------------------------------------------------
    // off time doubles per blink code, 1/16 s up to 4 s
    //--------------------------------------------------------------------------
    always_ff @(posedge clk32K or posedge rst) begin
        if (rst) begin
            // default blink code so the first off period is a full second
            off_max_cnt <= STEADY_W'(OFF_BASE_CNT) << (DEF_BLINK - 1'b1);
        end else if (blink_s != BLINK_STEADY_ON && blink_s <= MAX_RATE_CODE) begin
            off_max_cnt <= STEADY_W'(OFF_BASE_CNT) << (blink_s - 1'b1);
        end else begin
            off_max_cnt <= '0;
        end
    end

    //--------------------------------------------------------------------------
    // ramp time doubles per code and the step halves with it
    //--------------------------------------------------------------------------
    always_ff @(posedge clk32K or posedge rst) begin
        if (rst) begin
            ramp_max_cnt <= '0;
            step_shift   <= '0;
        end else if (ramp_s != '0 && ramp_s <= MAX_RATE_CODE) begin
            ramp_max_cnt <= RAMP_W'(RAMP_BASE_CNT) << (ramp_s - 1'b1);
            step_shift   <= SHIFT_W'(RAMP_BASE_SHIFT) + SHIFT_W'(ramp_s) - 1'b1;
        end else begin
            ramp_max_cnt <= '0;
            step_shift   <= '0;    // no ramp, zero step
        end
    end

endmodule

//--- verilog/led_blink_fsm.sv
`timescale 1ns/10ps

module led_blink_fsm (
    input  logic                          clk32K,
    input  logic                          rst,
    input  logic                          update,
    input  led_pkg::setting_t             blink_s,
    input  logic [led_pkg::STEADY_W-1:0]  off_max_cnt,
    input  logic [led_pkg::RAMP_W-1:0]    ramp_max_cnt,
    output led_pkg::blink_state_t         state
);
    import led_pkg::*;

    logic [STEADY_W-1:0] steady_count;    // off and on duration
    logic [RAMP_W-1:0]   ramp_count;      // ramp up/down duration

    //--------------------------------------------------------------------------
    // off -> ramp up -> on -> ramp down, held by the steady codes
    //--------------------------------------------------------------------------
    always_ff @(posedge clk32K or posedge rst) begin
        if (rst) begin
            state        <= LED_OFF;
            steady_count <= '0;
            ramp_count   <= '0;
        end else if (blink_s == BLINK_STEADY_ON) begin
            state        <= LED_ON;
            steady_count <= '0;
            ramp_count   <= '0;
        end else if (blink_s == BLINK_STEADY_OFF) begin
            state        <= LED_OFF;
            steady_count <= '0;
            ramp_count   <= '0;
        end else if (update) begin
            // new settings restart the cycle from full on
            state        <= LED_ON;
            steady_count <= '0;
            ramp_count   <= '0;
        end else begin
            case (state)
                LED_OFF: begin
                    if (steady_count >= off_max_cnt) begin
                        state        <= RAMP_UP;
                        steady_count <= '0;
                        ramp_count   <= '0;
                    end else begin
                        steady_count <= steady_count + 1'b1;
                    end
                end
                RAMP_UP: begin
                    if (ramp_count >= ramp_max_cnt) begin
                        state        <= LED_ON;
                        steady_count <= '0;
                        ramp_count   <= '0;
                    end else begin
                        ramp_count <= ramp_count + 1'b1;
                    end
                end
                LED_ON: begin
                    if (steady_count >= STEADY_W'(ON_MAX_CNT)) begin
                        state        <= RAMP_DOWN;
                        steady_count <= '0;
                        ramp_count   <= '0;
                    end else begin
                        steady_count <= steady_count + 1'b1;
                    end
                end
                RAMP_DOWN: begin
                    if (ramp_count >= ramp_max_cnt) begin
                        state        <= LED_OFF;
                        steady_count <= '0;
                        ramp_count   <= '0;
                    end else begin
                        ramp_count <= ramp_count + 1'b1;
                    end
                end
                default: begin
                    state        <= LED_OFF;
                    steady_count <= '0;
                    ramp_count   <= '0;
                end
            endcase
        end
    end

endmodule

//--- verilog/led_channel_ramp.sv
`timescale 1ns/10ps

module led_channel_ramp (
    input  logic                         clk32K,
    input  logic                         rst,
    input  led_pkg::blink_state_t        state,
    input  logic [led_pkg::ACCUM_W-1:0]  peak,
    input  logic [led_pkg::SHIFT_W-1:0]  step_shift,
    output logic [led_pkg::DUTY_W-1:0]   duty
);
    import led_pkg::*;

    logic [STEP_W-1:0]  step;
    logic [ACCUM_W-1:0] accum;

    always_ff @(posedge clk32K or posedge rst) begin
        if (rst) begin
            step <= '0;
        end else if (step_shift == '0) begin
            step <= '0;    // ramp disabled
        end else begin
            step <= STEP_W'(peak) >> step_shift;
        end
    end

    // ramp accumulator, one step per clk32K cycle
    always_ff @(posedge clk32K or posedge rst) begin
        if (rst) begin
            accum <= '0;
        end else begin
            case (state)
                LED_ON:    accum <= peak;
                RAMP_UP:   accum <= accum + step[ACCUM_W-1:0];
                RAMP_DOWN: accum <= accum - step[ACCUM_W-1:0];
                default:   accum <= '0;
            endcase
        end
    end

    always_ff @(posedge clk32K or posedge rst) begin
        if (rst) begin
            duty <= '0;
        end else begin
            case (state)
                LED_ON:             duty <= peak[DUTY_LSB +: DUTY_W];
                RAMP_UP, RAMP_DOWN: duty <= accum[DUTY_LSB +: DUTY_W];
                default:            duty <= '0;
            endcase
        end
    end

endmodule

//--- verilog/led_pwm.sv
`timescale 1ns/10ps

module led_pwm (
    input  logic                        clk32K,
    input  logic                        rst,
    input  logic [led_pkg::DUTY_W-1:0]  red_duty,
    input  logic [led_pkg::DUTY_W-1:0]  grn_duty,
    input  logic [led_pkg::DUTY_W-1:0]  blu_duty,
    output logic                        red_pwm,
    output logic                        grn_pwm,
    output logic                        blu_pwm
);
    import led_pkg::*;

    logic [PWM_CNT_W-1:0] pwm_count;
    logic [DUTY_W-1:0]    frame_pos;    // count widened to duty width

    assign frame_pos = DUTY_W'(pwm_count);

    always_ff @(posedge clk32K or posedge rst) begin
        if (rst) begin
            pwm_count <= '0;
            red_pwm   <= 1'b0;
            grn_pwm   <= 1'b0;
            blu_pwm   <= 1'b0;
        end else begin
            if (pwm_count == PWM_CNT_W'(PWM_PERIOD - 1)) begin
                pwm_count <= '0;
            end else begin
                pwm_count <= pwm_count + 1'b1;
            end
            // duty of 256 keeps the output high all frame
            red_pwm <= (frame_pos < red_duty);
            grn_pwm <= (frame_pos < grn_duty);
            blu_pwm <= (frame_pos < blu_duty);
        end
    end

endmodule

//--- verilog/led_control.sv
`timescale 1ns/10ps

module led_control (
    input  logic              clk32K,
    input  logic              rst,
    input  logic              params_ok,    // rising level means settings valid
    input  led_pkg::setting_t rgb_color,
    input  led_pkg::setting_t brightness,
    input  led_pkg::setting_t breathe_ramp,
    input  led_pkg::setting_t blink_rate,
    output logic              red_pwm,
    output logic              grn_pwm,
    output logic              blu_pwm
);
    import led_pkg::*;

    logic                update;
    setting_t            colour_s;
    setting_t            bright_s;
    setting_t            ramp_s;
    setting_t            blink_s;

    logic [ACCUM_W-1:0]  red_peak;
    logic [ACCUM_W-1:0]  grn_peak;
    logic [ACCUM_W-1:0]  blu_peak;

    logic [STEADY_W-1:0] off_max_cnt;
    logic [RAMP_W-1:0]   ramp_max_cnt;
    logic [SHIFT_W-1:0]  step_shift;

    blink_state_t        state;

    logic [DUTY_W-1:0]   red_duty;
    logic [DUTY_W-1:0]   grn_duty;
    logic [DUTY_W-1:0]   blu_duty;

    //--------------------------------------------------------------------------
    // settings capture and decode
    //--------------------------------------------------------------------------
    led_param_capture capture_i (
        .clk32K       (clk32K),
        .rst          (rst),
        .params_ok    (params_ok),
        .rgb_color    (rgb_color),
        .brightness   (brightness),
        .breathe_ramp (breathe_ramp),
        .blink_rate   (blink_rate),
        .update       (update),
        .colour_s     (colour_s),
        .bright_s     (bright_s),
        .ramp_s       (ramp_s),
        .blink_s      (blink_s)
    );

    led_colour_peak peak_i (
        .clk32K   (clk32K),
        .rst      (rst),
        .colour_s (colour_s),
        .bright_s (bright_s),
        .red_peak (red_peak),
        .grn_peak (grn_peak),
        .blu_peak (blu_peak)
    );

    led_rate_decode rate_i (
        .clk32K       (clk32K),
        .rst          (rst),
        .blink_s      (blink_s),
        .ramp_s       (ramp_s),
        .off_max_cnt  (off_max_cnt),
        .ramp_max_cnt (ramp_max_cnt),
        .step_shift   (step_shift)
    );

    //--------------------------------------------------------------------------
    // blink sequencing, per channel ramps and PWM
    //--------------------------------------------------------------------------
    led_blink_fsm fsm_i (
        .clk32K       (clk32K),
        .rst          (rst),
        .update       (update),
        .blink_s      (blink_s),
        .off_max_cnt  (off_max_cnt),
        .ramp_max_cnt (ramp_max_cnt),
        .state        (state)
    );

    led_channel_ramp red_ramp_i (
        .clk32K     (clk32K),
        .rst        (rst),
        .state      (state),
        .peak       (red_peak),
        .step_shift (step_shift),
        .duty       (red_duty)
    );

    led_channel_ramp grn_ramp_i (
        .clk32K     (clk32K),
        .rst        (rst),
        .state      (state),
        .peak       (grn_peak),
        .step_shift (step_shift),
        .duty       (grn_duty)
    );

    led_channel_ramp blu_ramp_i (
        .clk32K     (clk32K),
        .rst        (rst),
        .state      (state),
        .peak       (blu_peak),
        .step_shift (step_shift),
        .duty       (blu_duty)
    );

    led_pwm pwm_i (
        .clk32K   (clk32K),
        .rst      (rst),
        .red_duty (red_duty),
        .grn_duty (grn_duty),
        .blu_duty (blu_duty),
        .red_pwm  (red_pwm),
        .grn_pwm  (grn_pwm),
        .blu_pwm  (blu_pwm)
    );

endmodule

//--- verification/tb_led_control.sv
`timescale 1ns/10ps

module tb_led_control;
    import led_pkg::*;

    logic     clk32K;
    logic     rst;
    logic     params_ok;
    setting_t rgb_color;
    setting_t brightness;
    setting_t breathe_ramp;
    setting_t blink_rate;
    logic     red_pwm;
    logic     grn_pwm;
    logic     blu_pwm;

    logic     check_dark;    // all outputs low while set
    int       red_cnt;       // high cycles in the last frame
    int       grn_cnt;
    int       blu_cnt;

    led_control dut_i (
        .clk32K       (clk32K),
        .rst          (rst),
        .params_ok    (params_ok),
        .rgb_color    (rgb_color),
        .brightness   (brightness),
        .breathe_ramp (breathe_ramp),
        .blink_rate   (blink_rate),
        .red_pwm      (red_pwm),
        .grn_pwm      (grn_pwm),
        .blu_pwm      (blu_pwm)
    );

    always #20 clk32K = ~clk32K;    // 40 ns period

    //--------------------------------------------------------------------------
    // failure reporting
    //--------------------------------------------------------------------------
    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("Error %s: expected %0d, actual %0d", name, expected, actual);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    dark_check: assert property (@(posedge clk32K) disable iff (rst)
        check_dark |-> !(red_pwm || grn_pwm || blu_pwm))
        else report_mismatch("dark_outputs", 0, int'($sampled({red_pwm, grn_pwm, blu_pwm})));

    //--------------------------------------------------------------------------
    // expected duties with levels packed as {red, grn, blu} where 2 is hi, 1 lo and 0 off
    //--------------------------------------------------------------------------
    function automatic logic [5:0] colour_levels(input int code);
        case (code)
            0:       return 6'b10_00_00;    // red
            1:       return 6'b10_01_00;    // orange
            2:       return 6'b10_10_00;    // yellow
            3:       return 6'b01_10_00;    // chartreuse
            4:       return 6'b00_10_00;    // green
            5:       return 6'b00_10_01;    // spring
            6:       return 6'b00_10_10;    // cyan
            7:       return 6'b00_01_10;    // azure
            8:       return 6'b00_00_10;    // blue
            9:       return 6'b01_00_10;    // violet
            10:      return 6'b10_00_10;    // magenta
            11:      return 6'b10_00_01;    // rose
            15:      return 6'b10_10_10;    // white
            default: return 6'b00_00_00;
        endcase
    endfunction

    function automatic int expected_duty(input logic [1:0] lvl, input int bright);
        case (lvl)
            2'd2:    return 16 * (bright + 1);
            2'd1:    return 8 * (bright + 1);
            default: return 0;
        endcase
    endfunction

    //--------------------------------------------------------------------------
    // stimulus and measurement
    //--------------------------------------------------------------------------
    task automatic program_settings(input int colour, input int bright,
                                    input int ramp, input int blink);
        @(posedge clk32K);
        #1;
        rgb_color    = setting_t'(colour);
        brightness   = setting_t'(bright);
        breathe_ramp = setting_t'(ramp);
        blink_rate   = setting_t'(blink);
        params_ok    = 1'b1;
        repeat (3) @(posedge clk32K);
        #1;
        params_ok = 1'b0;    // settings stay as they are
    endtask

    // any 256 consecutive cycles hold exactly one PWM frame
    task automatic measure_frame();
        red_cnt = 0;
        grn_cnt = 0;
        blu_cnt = 0;
        repeat (256) begin
            @(negedge clk32K);
            red_cnt += int'(red_pwm);
            grn_cnt += int'(grn_pwm);
            blu_cnt += int'(blu_pwm);
        end
    endtask

    task automatic check_colour(input string name, input int code, input int bright);
        logic [5:0] lvl;
        lvl = colour_levels(code);
        measure_frame();
        assert (red_cnt == expected_duty(lvl[5:4], bright))
            else report_mismatch({name, " red"}, expected_duty(lvl[5:4], bright), red_cnt);
        assert (grn_cnt == expected_duty(lvl[3:2], bright))
            else report_mismatch({name, " grn"}, expected_duty(lvl[3:2], bright), grn_cnt);
        assert (blu_cnt == expected_duty(lvl[1:0], bright))
            else report_mismatch({name, " blu"}, expected_duty(lvl[1:0], bright), blu_cnt);
    endtask

    task automatic wait_red_frame(input string what, input int target, input int max_frames);
        int frames;
        frames = 0;
        measure_frame();
        while (red_cnt != target) begin
            frames++;
            if (frames >= max_frames)
                report_failure({"timeout waiting for ", what});
            else
                measure_frame();
        end
    endtask

    initial begin
        int          bright;
        int          frames;
        int          prev;
        bit          seen_mid;

        void'($urandom(32'h86c0_19a0));
        clk32K       = 1'b0;
        rst          = 1'b1;
        params_ok    = 1'b0;
        rgb_color    = '0;
        brightness   = '0;
        breathe_ramp = '0;
        blink_rate   = '0;
        check_dark   = 1'b0;
        repeat (2) @(posedge clk32K);
        #1;
        rst        = 1'b0;
        check_dark = 1'b1;    // default blink starts with a long off time
        repeat (1000) @(posedge clk32K);
        #1;
        check_dark = 1'b0;

        // steady on for every colour code
        for (int code = 0; code < 16; code++) begin
            bright = $urandom % 16;
            program_settings(code, bright, 0, 0);
            measure_frame();    // settle
            check_colour($sformatf("steady_colour %0d", code), code, bright);
        end

        // steady off with white at full brightness
        program_settings(15, 15, 0, 8);
        measure_frame();
        check_dark = 1'b1;
        repeat (2) begin
            measure_frame();
            assert (red_cnt + grn_cnt + blu_cnt == 0)
                else report_mismatch("steady_off", 0, red_cnt + grn_cnt + blu_cnt);
        end
        check_dark = 1'b0;

        // fastest blink without ramp
        bright = $urandom % 16;
        program_settings(0, bright, 0, 1);
        measure_frame();
        check_colour("blink_on", 0, bright);
        wait_red_frame("blink off", 0, 160);
        wait_red_frame("blink back on", 16 * (bright + 1), 12);

        //--------------------------------------------------------------------------
        // breathe on green ramps down then up
        //--------------------------------------------------------------------------
        program_settings(4, 15, 1, 1);
        measure_frame();
        frames = 0;
        measure_frame();
        while (grn_cnt == 256) begin
            frames++;
            if (frames >= 160)
                report_failure("timeout waiting for breathe ramp down");
            else
                measure_frame();
        end
        seen_mid = 1'b0;
        frames   = 0;
        while (grn_cnt != 0) begin
            frames++;
            if (frames >= 12) begin
                report_failure("timeout waiting for breathe to reach off");
            end else begin
                prev = grn_cnt;
                measure_frame();
                assert (grn_cnt <= prev) else report_mismatch("breathe_fall", prev, grn_cnt);
                if (grn_cnt > 0 && grn_cnt < 256)
                    seen_mid = 1'b1;    // a frame wholly inside the ramp
            end
        end
        assert (seen_mid) else report_failure("breathe ramp down had no partial frame");
        frames = 0;
        while (grn_cnt == 0) begin
            frames++;
            if (frames >= 16)
                report_failure("timeout waiting for breathe ramp up");
            else
                measure_frame();
        end
        frames = 0;
        while (grn_cnt != 256) begin
            frames++;
            if (frames >= 12) begin
                report_failure("timeout waiting for breathe to reach full");
            end else begin
                prev = grn_cnt;
                measure_frame();
                assert (grn_cnt >= prev) else report_mismatch("breathe_rise", prev, grn_cnt);
            end
        end

        // slow blink interrupted by new settings
        bright = $urandom % 16;
        program_settings(0, bright, 0, 7);
        wait_red_frame("slow blink off", 0, 160);
        bright = $urandom % 16;
        program_settings(2, bright, 0, 7);
        wait_red_frame("restart on update", 16 * (bright + 1), 2);
        check_colour("restart_on_update", 2, bright);

        $display("sim passed");
        $finish;
    end

endmodule

//--- led_control.f
verilog/led_pkg.sv
verilog/led_param_capture.sv
verilog/led_colour_peak.sv
verilog/led_rate_decode.sv
verilog/led_blink_fsm.sv
verilog/led_channel_ramp.sv
verilog/led_pwm.sv
verilog/led_control.sv
verification/tb_led_control.sv
